// ==== Bender.yml ====
package:
  name: commit_core

export_include_dirs:
  - common

sources:
  - files:
      - common/rob_pkg.sv
      - rob/rob.sv
      - verilog/retire_unit.sv
      - verilog/arch_regfile.sv
      - verilog/operand_resolve.sv
      - verilog/commit_core.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/commit_core_checker.sv
      - verification/commit_core_sva.sv
      - verification/commit_core_tb.sv

// ==== common/rob_macros.svh ====
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// Reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3
`define ROB_CNT_W 4

// Reserve and retire lanes per cycle
`define ROB_LANES 2

// Datapath
`define XLEN 32
`define REG_ADDR_W 5

`endif

// ==== common/rob_pkg.sv ====
`include "rob_macros.svh"

package rob_pkg;

  // Lifecycle of one occupied slot
  typedef enum logic [1:0] {
    SLOT_PENDING = 2'd0,
    SLOT_DONE    = 2'd1,
    SLOT_KILLED  = 2'd2
  } rob_slot_state_t;

  // Payload kept per slot
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] dest_reg;
    logic                   dest_reg_valid;
    logic [`XLEN-1:0]       result;
  } rob_entry_t;

endpackage

// ==== rob/rob.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob (
  input  logic                                  clock,
  input  logic                                  reset_n,
  input  logic                                  reserve_i,
  input  logic [$clog2(`ROB_LANES)-1:0]         reserve_count_i,
  input  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] dest_reg_i,
  input  logic [`ROB_LANES-1:0]                 dest_reg_valid_i,
  input  logic                                  write_valid_i,
  input  logic [`ROB_IDX_W-1:0]                 write_slot_i,
  input  logic [`XLEN-1:0]                      write_data_i,
  input  logic                                  flush_i,
  input  logic [`ROB_IDX_W-1:0]                 flush_idx_i,
  input  logic                                  consume_i,
  input  logic [$clog2(`ROB_LANES)-1:0]         consume_count_i,
  input  logic [`ROB_IDX_W-1:0]                 lookup_idx_i,
  input  logic [`REG_ADDR_W-1:0]                lookup_reg_i,
  output logic [`ROB_LANES-1:0][`ROB_IDX_W-1:0] reserved_slots_o,
  output logic                                  full_o,
  output logic                                  empty_o,
  output logic [`ROB_CNT_W-1:0]                 used_count_o,
  output rob_pkg::rob_slot_state_t [`ROB_LANES-1:0] head_state_o,
  output rob_pkg::rob_entry_t [`ROB_LANES-1:0]  head_entry_o,
  output logic [`ROB_LANES-1:0]                 head_occupied_o,
  output logic                                  lookup_hit_o,
  output logic                                  lookup_done_o,
  output logic [`XLEN-1:0]                      lookup_value_o,
  output logic [`ROB_IDX_W-1:0]                 lookup_slot_o
);
  import rob_pkg::*;

  localparam int IDX_W = `ROB_IDX_W;

  rob_entry_t      entries    [`ROB_DEPTH];
  rob_slot_state_t slot_state [`ROB_DEPTH];

  logic [IDX_W-1:0]      ins_ptr;
  logic [IDX_W-1:0]      ext_ptr;
  logic                  reserve_ok;
  logic                  consume_ok;
  logic [`ROB_CNT_W-1:0] ins_amt;
  logic [`ROB_CNT_W-1:0] ext_amt;
  logic [IDX_W-1:0]      slot_age   [`ROB_DEPTH];
  logic                  slot_live  [`ROB_DEPTH];
  logic [IDX_W-1:0]      flush_age;
  logic [IDX_W-1:0]      query_age;

  // Overflow and underflow guards
  assign reserve_ok = reserve_i & ~full_o;
  assign consume_ok = consume_i & ~empty_o;

  always_comb begin
    ins_amt = '0;
    ext_amt = '0;
    if (reserve_ok) begin
      ins_amt = reserve_count_i + 1'b1;
    end
    if (consume_ok) begin
      // Never extract more than is held
      if (used_count_o == 1) begin
        ext_amt = 1;
      end else begin
        ext_amt = consume_count_i + 1'b1;
      end
    end
  end

  // Age relative to the head decides liveness and ordering
  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      slot_age[i]  = IDX_W'(i) - ext_ptr;
      slot_live[i] = slot_age[i] < used_count_o;
    end
  end

  assign flush_age = flush_idx_i - ext_ptr;
  assign query_age = lookup_idx_i - ext_ptr;

  always_comb begin
    for (int l = 0; l < `ROB_LANES; l++) begin
      reserved_slots_o[l] = ins_ptr + IDX_W'(l);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ins_ptr      <= '0;
      ext_ptr      <= '0;
      used_count_o <= '0;
    end else begin
      ins_ptr      <= ins_ptr + IDX_W'(ins_amt);
      ext_ptr      <= ext_ptr + IDX_W'(ext_amt);
      used_count_o <= used_count_o + ins_amt - ext_amt;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        slot_state[i] <= SLOT_PENDING;
      end
    end else begin
      if (reserve_ok) begin
        for (int l = 0; l < `ROB_LANES; l++) begin
          if (l <= reserve_count_i) begin
            slot_state[reserved_slots_o[l]] <= SLOT_PENDING;
          end
        end
      end
      // A killed slot stays killed even if its result shows up late
      if (write_valid_i && slot_state[write_slot_i] != SLOT_KILLED) begin
        slot_state[write_slot_i] <= SLOT_DONE;
      end
      if (flush_i) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
          if (slot_live[i] && slot_age[i] > flush_age) begin
            slot_state[i] <= SLOT_KILLED;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reserve_ok) begin
      for (int l = 0; l < `ROB_LANES; l++) begin
        if (l <= reserve_count_i) begin
          entries[reserved_slots_o[l]].dest_reg       <= dest_reg_i[l];
          entries[reserved_slots_o[l]].dest_reg_valid <= dest_reg_valid_i[l];
        end
      end
    end
    if (write_valid_i) begin
      entries[write_slot_i].result <= write_data_i;
    end
  end

  // Oldest first, so the youngest match is the one left standing
  always_comb begin
    logic [IDX_W-1:0] k;
    lookup_hit_o   = 1'b0;
    lookup_done_o  = 1'b0;
    lookup_value_o = '0;
    lookup_slot_o  = '0;
    for (int a = 0; a < `ROB_DEPTH; a++) begin
      k = ext_ptr + IDX_W'(a);
      if (slot_live[k] && IDX_W'(a) < query_age && slot_state[k] != SLOT_KILLED &&
          entries[k].dest_reg_valid && entries[k].dest_reg == lookup_reg_i) begin
        lookup_hit_o   = 1'b1;
        lookup_done_o  = slot_state[k] == SLOT_DONE;
        lookup_value_o = entries[k].result;
        lookup_slot_o  = k;
      end
    end
  end

  always_comb begin
    logic [IDX_W-1:0] k;
    for (int l = 0; l < `ROB_LANES; l++) begin
      k                  = ext_ptr + IDX_W'(l);
      head_state_o[l]    = slot_state[k];
      head_entry_o[l]    = entries[k];
      head_occupied_o[l] = l < used_count_o;
    end
  end

  assign empty_o = used_count_o == 0;
  assign full_o  = used_count_o > (`ROB_DEPTH - `ROB_LANES);

endmodule

// ==== tb.f ====
+incdir+common
common/rob_pkg.sv
rob/rob.sv
verilog/retire_unit.sv
verilog/arch_regfile.sv
verilog/operand_resolve.sv
verilog/commit_core.sv
verification/tb_clock_gen.sv
verification/commit_core_checker.sv
verification/commit_core_sva.sv
verification/commit_core_tb.sv

// ==== verification/commit_core_checker.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module commit_core_checker (
  input  logic                                   clock,
  input  logic                                   reset_n,
  input  logic                                   reserve_i,
  input  logic                                   reserve_count_i,
  input  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] dest_reg_i,
  input  logic [`ROB_LANES-1:0]                  dest_reg_valid_i,
  input  logic                                   write_valid_i,
  input  logic [`ROB_IDX_W-1:0]                  write_slot_i,
  input  logic [`XLEN-1:0]                       write_data_i,
  input  logic                                   flush_i,
  input  logic [`ROB_IDX_W-1:0]                  flush_idx_i,
  input  logic [`ROB_IDX_W-1:0]                  query_idx_i,
  input  logic [`REG_ADDR_W-1:0]                 src_reg_i,
  input  logic                                   full_o,
  input  logic [`ROB_LANES-1:0][`ROB_IDX_W-1:0]  reserved_slots_o,
  input  logic                                   empty_o,
  input  logic [`ROB_CNT_W-1:0]                  used_count_o,
  input  logic [`ROB_LANES-1:0]                  retire_valid_o,
  input  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] retire_reg_o,
  input  logic [`ROB_LANES-1:0][`XLEN-1:0]       retire_data_o,
  input  logic [`XLEN-1:0]                       src_value_o,
  input  logic                                   src_ready_o,
  input  logic [`ROB_IDX_W-1:0]                  src_tag_o,
  input  logic                                   check_i,
  input  logic [`XLEN-1:0]                       exp_value_i,
  input  logic                                   exp_ready_i,
  input  logic [`ROB_IDX_W-1:0]                  exp_tag_i,
  input  logic [95:0]                            name_i
);

  localparam logic [1:0] PEND = 2'd0;
  localparam logic [1:0] DONE = 2'd1;
  localparam logic [1:0] KILL = 2'd2;

  logic [1:0]             m_state  [`ROB_DEPTH];
  logic [`REG_ADDR_W-1:0] m_dest   [`ROB_DEPTH];
  logic                   m_dvalid [`ROB_DEPTH];
  logic [`XLEN-1:0]       m_data   [`ROB_DEPTH];
  logic [`XLEN-1:0]       m_rf     [32];
  logic [`ROB_IDX_W-1:0]  head;
  int                     count;
  int                     retire_n;
  int                     flag_errors;
  int                     retire_errors;
  int                     lookup_errors;

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch %0s %0s: expected %h actual %h", name_i, what, exp, act);
  endtask

  task automatic check_flags();
    logic [`ROB_IDX_W-1:0] slot;
    if (full_o !== (count > `ROB_DEPTH - `ROB_LANES)) begin
      report_mismatch("full_o", count > `ROB_DEPTH - `ROB_LANES, full_o);
      flag_errors++;
    end
    if (empty_o !== (count == 0)) begin
      report_mismatch("empty_o", count == 0, empty_o);
      flag_errors++;
    end
    if (used_count_o !== count[`ROB_CNT_W-1:0]) begin
      report_mismatch("used_count_o", count, used_count_o);
      flag_errors++;
    end
    // Next free slots follow the youngest occupied one
    for (int l = 0; l < `ROB_LANES; l++) begin
      slot = head + count[`ROB_IDX_W-1:0] + l[`ROB_IDX_W-1:0];
      if (reserved_slots_o[l] !== slot) begin
        report_mismatch($sformatf("reserved_slots lane %0d", l), slot, reserved_slots_o[l]);
        flag_errors++;
      end
    end
  endtask

  // Leading finished slots leave in order, only DONE ones with a destination write
  task automatic check_retire();
    logic [`ROB_IDX_W-1:0] s;
    logic                  wr;
    retire_n = 0;
    for (int l = 0; l < `ROB_LANES; l++) begin
      s  = head + l[`ROB_IDX_W-1:0];
      wr = 1'b0;
      if (l < count && retire_n == l && m_state[s] != PEND) begin
        retire_n++;
        wr = m_state[s] == DONE && m_dvalid[s];
      end
      if (retire_valid_o[l] !== wr) begin
        report_mismatch($sformatf("retire_valid lane %0d", l), wr, retire_valid_o[l]);
        retire_errors++;
      end else if (wr) begin
        if (retire_reg_o[l] !== m_dest[s]) begin
          report_mismatch($sformatf("retire reg lane %0d", l), m_dest[s], retire_reg_o[l]);
          retire_errors++;
        end
        if (retire_data_o[l] !== m_data[s]) begin
          report_mismatch($sformatf("retire data lane %0d", l), m_data[s], retire_data_o[l]);
          retire_errors++;
        end
        if (m_dest[s] != 0) begin
          m_rf[m_dest[s]] = m_data[s];
        end
      end
    end
  endtask

  task automatic check_lookup();
    logic [`ROB_IDX_W-1:0] s;
    logic [`ROB_IDX_W-1:0] query_age;
    logic                  in_flight;
    if (check_i) begin
      if (src_ready_o !== exp_ready_i) begin
        report_mismatch("src_ready", exp_ready_i, src_ready_o);
        lookup_errors++;
      end
      if (src_value_o !== exp_value_i) begin
        report_mismatch("src_value", exp_value_i, src_value_o);
        lookup_errors++;
      end
      if (src_tag_o !== exp_tag_i) begin
        report_mismatch("src_tag", exp_tag_i, src_tag_o);
        lookup_errors++;
      end
      // With no older live producer the value comes from the register model
      query_age = query_idx_i - head;
      in_flight = 1'b0;
      for (int a = 0; a < count; a++) begin
        s = head + a[`ROB_IDX_W-1:0];
        if (a < query_age && m_state[s] != KILL && m_dvalid[s] && m_dest[s] == src_reg_i) begin
          in_flight = 1'b1;
        end
      end
      if (!in_flight && src_value_o !== m_rf[src_reg_i]) begin
        report_mismatch("src_value vs register model", m_rf[src_reg_i], src_value_o);
        lookup_errors++;
      end
    end
  endtask

  task automatic apply_inputs();
    logic [`ROB_IDX_W-1:0] s;
    logic [`ROB_IDX_W-1:0] flush_age;
    int                    added;
    added = 0;
    if (write_valid_i) begin
      m_data[write_slot_i] = write_data_i;
      if (m_state[write_slot_i] != KILL) begin
        m_state[write_slot_i] = DONE;
      end
    end
    if (flush_i) begin
      flush_age = flush_idx_i - head;
      for (int a = 0; a < count; a++) begin
        if (a > flush_age) begin
          m_state[head + a[`ROB_IDX_W-1:0]] = KILL;
        end
      end
    end
    if (reserve_i && !(count > `ROB_DEPTH - `ROB_LANES)) begin
      for (int l = 0; l <= reserve_count_i; l++) begin
        s = head + count[`ROB_IDX_W-1:0] + l[`ROB_IDX_W-1:0];
        m_state[s]  = PEND;
        m_dest[s]   = dest_reg_i[l];
        m_dvalid[s] = dest_reg_valid_i[l];
      end
      added = reserve_count_i + 1;
    end
    head  = head + retire_n[`ROB_IDX_W-1:0];
    count = count + added - retire_n;
  endtask

  always @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head  = '0;
      count = 0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        m_state[i] = PEND;
      end
      for (int r = 0; r < 32; r++) begin
        m_rf[r] = '0;
      end
    end else begin
      check_flags();
      check_lookup();
      check_retire();
      apply_inputs();
    end
  end

  initial begin
    flag_errors   = 0;
    retire_errors = 0;
    lookup_errors = 0;
  end

endmodule

// ==== verification/commit_core_sva.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module commit_core_sva (
  input logic                                      clock,
  input logic                                      reset_n,
  input logic [`ROB_CNT_W-1:0]                     used_count,
  input logic                                      full,
  input logic                                      reserve,
  input logic [`ROB_IDX_W-1:0]                     ins_ptr,
  input logic [`ROB_IDX_W-1:0]                     ext_ptr,
  input rob_pkg::rob_slot_state_t [`ROB_LANES-1:0] head_state,
  input logic [`ROB_LANES-1:0]                     head_occupied,
  input logic [`ROB_LANES-1:0]                     leaving,
  input logic [31:0]                               retired_total
);
  import rob_pkg::*;

  int assert_errors = 0;

  assert property (@(posedge clock) disable iff (!reset_n) used_count <= `ROB_DEPTH)
    else begin
      $error("Buffer occupancy above depth");
      assert_errors++;
    end

  // A dropped reserve leaves the insert pointer where it was
  assert property (@(posedge clock) disable iff (!reset_n)
    full && reserve |=> ins_ptr == $past(ins_ptr))
    else begin
      $error("Reserve accepted while full");
      assert_errors++;
    end

  // Lane 1 may only follow an occupied, finished lane 0
  assert property (@(posedge clock) disable iff (!reset_n)
    leaving[1] |-> head_occupied[0] && head_state[0] != SLOT_PENDING)
    else begin
      $error("Lane 1 retired without lane 0");
      assert_errors++;
    end

  // Retired slots and the extract pointer advance together
  assert property (@(posedge clock) disable iff (!reset_n)
    retired_total[`ROB_IDX_W-1:0] == ext_ptr)
    else begin
      $error("Retired slot total out of step with the head pointer");
      assert_errors++;
    end

endmodule

bind commit_core commit_core_sva sva_i (
  .clock         (clock),
  .reset_n       (reset_n),
  .used_count    (rob_i.used_count_o),
  .full          (rob_i.full_o),
  .reserve       (rob_i.reserve_i),
  .ins_ptr       (rob_i.ins_ptr),
  .ext_ptr       (rob_i.ext_ptr),
  .head_state    (rob_i.head_state_o),
  .head_occupied (rob_i.head_occupied_o),
  .leaving       (retire_unit_i.leaving),
  .retired_total (retire_unit_i.retired_total)
);

// ==== verification/commit_core_tb.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module commit_core_tb;

  typedef enum logic [2:0] {
    OP_IDLE, OP_RESERVE, OP_WRITE, OP_FLUSH, OP_LOOKUP, OP_DRAIN
  } op_t;

  typedef struct packed {
    op_t         op;
    logic        grp;
    logic        cnt;
    logic [4:0]  reg_a;
    logic [4:0]  reg_b;
    logic [2:0]  idx;
    logic [31:0] data;
    logic [31:0] exp_value;
    logic        exp_ready;
    logic [2:0]  exp_tag;
    logic [95:0] name;
  } row_t;

  logic clock;
  logic reset_n;
  logic reserve_i;
  logic reserve_count_i;
  logic [1:0][4:0] dest_reg_i;
  logic [1:0] dest_reg_valid_i;
  logic full_o;
  logic [1:0][2:0] reserved_slots_o;
  logic write_valid_i;
  logic [2:0] write_slot_i;
  logic [31:0] write_data_i;
  logic flush_i;
  logic [2:0] flush_idx_i;
  logic [2:0] query_idx_i;
  logic [4:0] src_reg_i;
  logic [31:0] src_value_o;
  logic src_ready_o;
  logic [2:0] src_tag_o;
  logic empty_o;
  logic [3:0] used_count_o;
  logic [1:0] retire_valid_o;
  logic [1:0][4:0] retire_reg_o;
  logic [1:0][31:0] retire_data_o;
  logic check;
  logic [31:0] exp_value;
  logic exp_ready;
  logic [2:0] exp_tag;
  logic [95:0] name;

  row_t rows[$];
  int   limit;
  int   cycles;
  logic finished;

  tb_clock_gen clock_gen_i (.clock(clock), .reset_n(reset_n));

  commit_core dut_i (.*);

  commit_core_checker checker_i (.*, .check_i(check), .exp_value_i(exp_value),
    .exp_ready_i(exp_ready), .exp_tag_i(exp_tag), .name_i(name));

  task automatic add_row(input op_t op, input logic grp, input logic cnt, input logic [4:0] ra,
                         input logic [4:0] rb, input logic [2:0] idx, input logic [31:0] data,
                         input logic [31:0] ev, input logic er, input logic [2:0] et,
                         input logic [95:0] nm);
    rows.push_back('{op, grp, cnt, ra, rb, idx, data, ev, er, et, nm});
  endtask

  task automatic add_reserve(input logic cnt, input logic [4:0] ra, input logic [4:0] rb,
                             input logic [95:0] nm);
    add_row(OP_RESERVE, 0, cnt, ra, rb, 0, 0, 0, 0, 0, nm);
  endtask

  task automatic add_write(input logic [2:0] slot, input logic [31:0] data, input logic grp,
                           input logic [95:0] nm);
    add_row(OP_WRITE, grp, 0, 0, 0, slot, data, 0, 0, 0, nm);
  endtask

  task automatic add_lookup(input logic [2:0] idx, input logic [4:0] rs, input logic [31:0] ev,
                            input logic er, input logic [2:0] et, input logic [95:0] nm);
    add_row(OP_LOOKUP, 0, 0, rs, 0, idx, 0, ev, er, et, nm);
  endtask

  task automatic build_table();
    add_lookup(0, 5, 0, 1, 0, "reset_look");
    // In order pair
    add_reserve(1, 3, 4, "in_order");
    add_write(0, 32'h11, 0, "in_order");
    add_write(1, 32'h22, 0, "in_order");
    add_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, 0, 0, "in_order");
    add_lookup(2, 3, 32'h11, 1, 0, "rf_look_a");
    add_lookup(2, 4, 32'h22, 1, 0, "rf_look_b");
    // Out of order group, shuffled later
    add_reserve(1, 6, 7, "out_order");
    add_reserve(1, 8, 9, "out_order");
    add_write(2, 32'h33, 1, "out_order");
    add_write(3, 32'h44, 1, "out_order");
    add_write(4, 32'h55, 1, "out_order");
    add_write(5, 32'h66, 1, "out_order");
    add_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, 0, 0, "out_order");
    add_lookup(6, 8, 32'h55, 1, 0, "ooo_look");
    // Slot 6 pending holds the head
    add_reserve(1, 12, 10, "fwd_setup");
    add_reserve(1, 10, 11, "fwd_setup");
    add_write(7, 32'h77, 0, "fwd_setup");
    add_lookup(0, 10, 32'h77, 1, 7, "fwd_done");
    add_lookup(1, 10, 0, 0, 0, "fwd_pending");
    add_lookup(2, 6, 32'h33, 1, 0, "fwd_rf");
    add_write(0, 32'h88, 0, "fwd_finish");
    add_write(1, 32'h99, 0, "fwd_finish");
    add_write(6, 32'h66, 0, "fwd_finish");
    add_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, 0, 0, "fwd_finish");
    add_lookup(2, 10, 32'h88, 1, 0, "fwd_after");
    // Flush kills slots 4 and 5
    add_reserve(1, 13, 14, "flush");
    add_reserve(1, 13, 15, "flush");
    add_write(4, 32'hb1, 0, "flush");
    add_write(5, 32'hb2, 0, "flush");
    add_row(OP_FLUSH, 0, 0, 0, 0, 3, 0, 0, 0, 0, "flush");
    add_lookup(6, 13, 0, 0, 2, "flush_look");
    add_write(2, 32'ha1, 0, "flush");
    add_write(3, 32'ha2, 0, "flush");
    add_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, 0, 0, "flush");
    add_lookup(6, 13, 32'ha1, 1, 0, "flush_old");
    add_lookup(6, 15, 0, 1, 0, "flush_none");
    // Fill to seven, then one dropped reserve
    add_reserve(1, 16, 17, "fill");
    add_reserve(1, 16, 17, "fill");
    add_reserve(1, 16, 17, "fill");
    add_reserve(0, 16, 17, "fill");
    add_reserve(1, 16, 17, "fill_drop");
    for (int s = 6; s < 13; s++) begin
      add_write(s[2:0], 32'hc0 + s[2:0], 0, "fill_write");
    end
    add_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, 0, 0, "fill_write");
    add_lookup(5, 17, 32'hc3, 1, 0, "fill_look_a");
    add_lookup(5, 16, 32'hc4, 1, 0, "fill_look_b");
  endtask

  // Random write order inside the group
  task automatic shuffle_group();
    int   members[$];
    int   j;
    row_t tmp;
    foreach (rows[i]) begin
      if (rows[i].grp) begin
        members.push_back(i);
      end
    end
    for (int i = members.size() - 1; i > 0; i--) begin
      j = $urandom_range(i, 0);
      tmp = rows[members[i]];
      rows[members[i]] = rows[members[j]];
      rows[members[j]] = tmp;
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit && !finished) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int total;
    void'($urandom(32'ha7c8_1478));
    {reserve_i, reserve_count_i, dest_reg_i, dest_reg_valid_i} = '0;
    {write_valid_i, write_slot_i, write_data_i, flush_i, flush_idx_i} = '0;
    {query_idx_i, src_reg_i, check, exp_value, exp_ready, exp_tag, name} = '0;
    cycles   = 0;
    limit    = 0;
    finished = 1'b0;
    build_table();
    shuffle_group();
    limit = rows.size() * 4 + 50;
    @(posedge reset_n);
    foreach (rows[i]) begin
      @(posedge clock);
      reserve_i     <= rows[i].op == OP_RESERVE;
      write_valid_i <= rows[i].op == OP_WRITE;
      flush_i       <= rows[i].op == OP_FLUSH;
      check         <= rows[i].op == OP_LOOKUP;
      name          <= rows[i].name;
      reserve_count_i  <= rows[i].cnt;
      dest_reg_i       <= {rows[i].reg_b, rows[i].reg_a};
      dest_reg_valid_i <= 2'b11;
      write_slot_i  <= rows[i].idx;
      write_data_i  <= rows[i].data;
      flush_idx_i   <= rows[i].idx;
      query_idx_i   <= rows[i].idx;
      src_reg_i     <= rows[i].reg_a;
      exp_value     <= rows[i].exp_value;
      exp_ready     <= rows[i].exp_ready;
      exp_tag       <= rows[i].exp_tag;
      if (rows[i].op == OP_DRAIN) begin
        while (!empty_o) @(posedge clock);
      end
    end
    @(posedge clock);
    {reserve_i, write_valid_i, flush_i, check} <= '0;
    repeat (2) @(posedge clock);
    finished = 1'b1;
    total = checker_i.flag_errors + checker_i.retire_errors + checker_i.lookup_errors
            + dut_i.sva_i.assert_errors;
    $display("Errors: flags %0d, retire %0d, lookup %0d, assertions %0d",
             checker_i.flag_errors, checker_i.retire_errors, checker_i.lookup_errors,
             dut_i.sva_i.assert_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Two cycles of reset, released away from the edge
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clock);
    #10 reset_n = 1'b1;
  end

endmodule

// ==== verilog/arch_regfile.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module arch_regfile (
  input  logic                                   clock,
  input  logic                                   reset_n,
  input  logic [`ROB_LANES-1:0]                  we_i,
  input  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] waddr_i,
  input  logic [`ROB_LANES-1:0][`XLEN-1:0]       wdata_i,
  input  logic [`REG_ADDR_W-1:0]                 raddr_i,
  output logic [`XLEN-1:0]                       rdata_o
);

  localparam int NUM_REGS = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NUM_REGS];

  // Higher lane is younger and is applied last
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < `ROB_LANES; l++) begin
        if (we_i[l] && waddr_i[l] != '0) begin
          regs[waddr_i[l]] <= wdata_i[l];
        end
      end
    end
  end

  // x0 is hardwired
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// ==== verilog/commit_core.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module commit_core (
  input  logic                                   clock,
  input  logic                                   reset_n,
  input  logic                                   reserve_i,
  input  logic [$clog2(`ROB_LANES)-1:0]          reserve_count_i,
  input  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] dest_reg_i,
  input  logic [`ROB_LANES-1:0]                  dest_reg_valid_i,
  output logic                                   full_o,
  output logic [`ROB_LANES-1:0][`ROB_IDX_W-1:0]  reserved_slots_o,
  input  logic                                   write_valid_i,
  input  logic [`ROB_IDX_W-1:0]                  write_slot_i,
  input  logic [`XLEN-1:0]                       write_data_i,
  input  logic                                   flush_i,
  input  logic [`ROB_IDX_W-1:0]                  flush_idx_i,
  input  logic [`ROB_IDX_W-1:0]                  query_idx_i,
  input  logic [`REG_ADDR_W-1:0]                 src_reg_i,
  output logic [`XLEN-1:0]                       src_value_o,
  output logic                                   src_ready_o,
  output logic [`ROB_IDX_W-1:0]                  src_tag_o,
  output logic                                   empty_o,
  output logic [`ROB_CNT_W-1:0]                  used_count_o,
  output logic [`ROB_LANES-1:0]                  retire_valid_o,
  output logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] retire_reg_o,
  output logic [`ROB_LANES-1:0][`XLEN-1:0]       retire_data_o
);
  import rob_pkg::*;

  rob_slot_state_t [`ROB_LANES-1:0] head_state;
  rob_entry_t [`ROB_LANES-1:0]      head_entry;
  logic [`ROB_LANES-1:0]            head_occupied;
  logic                             consume;
  logic [$clog2(`ROB_LANES)-1:0]    consume_count;

  logic [`ROB_LANES-1:0]                  rf_we;
  logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] rf_waddr;
  logic [`ROB_LANES-1:0][`XLEN-1:0]       rf_wdata;
  logic [`REG_ADDR_W-1:0]                 rf_raddr;
  logic [`XLEN-1:0]                       rf_rdata;

  logic [`ROB_IDX_W-1:0]  lookup_idx;
  logic [`REG_ADDR_W-1:0] lookup_reg;
  logic                   lookup_hit;
  logic                   lookup_done;
  logic [`XLEN-1:0]       lookup_value;
  logic [`ROB_IDX_W-1:0]  lookup_slot;

  rob rob_i (
    .clock            (clock),
    .reset_n          (reset_n),
    .reserve_i        (reserve_i),
    .reserve_count_i  (reserve_count_i),
    .dest_reg_i       (dest_reg_i),
    .dest_reg_valid_i (dest_reg_valid_i),
    .write_valid_i    (write_valid_i),
    .write_slot_i     (write_slot_i),
    .write_data_i     (write_data_i),
    .flush_i          (flush_i),
    .flush_idx_i      (flush_idx_i),
    .consume_i        (consume),
    .consume_count_i  (consume_count),
    .lookup_idx_i     (lookup_idx),
    .lookup_reg_i     (lookup_reg),
    .reserved_slots_o (reserved_slots_o),
    .full_o           (full_o),
    .empty_o          (empty_o),
    .used_count_o     (used_count_o),
    .head_state_o     (head_state),
    .head_entry_o     (head_entry),
    .head_occupied_o  (head_occupied),
    .lookup_hit_o     (lookup_hit),
    .lookup_done_o    (lookup_done),
    .lookup_value_o   (lookup_value),
    .lookup_slot_o    (lookup_slot)
  );

  retire_unit retire_unit_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .head_state_i    (head_state),
    .head_entry_i    (head_entry),
    .head_occupied_i (head_occupied),
    .consume_o       (consume),
    .consume_count_o (consume_count),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .retire_valid_o  (retire_valid_o),
    .retire_reg_o    (retire_reg_o),
    .retire_data_o   (retire_data_o)
  );

  arch_regfile arch_regfile_i (
    .clock   (clock),
    .reset_n (reset_n),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata)
  );

  operand_resolve operand_resolve_i (
    .query_idx_i    (query_idx_i),
    .src_reg_i      (src_reg_i),
    .lookup_hit_i   (lookup_hit),
    .lookup_done_i  (lookup_done),
    .lookup_value_i (lookup_value),
    .lookup_slot_i  (lookup_slot),
    .rf_rdata_i     (rf_rdata),
    .lookup_idx_o   (lookup_idx),
    .lookup_reg_o   (lookup_reg),
    .rf_raddr_o     (rf_raddr),
    .src_value_o    (src_value_o),
    .src_ready_o    (src_ready_o),
    .src_tag_o      (src_tag_o)
  );

endmodule

// ==== verilog/operand_resolve.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module operand_resolve (
  input  logic [`ROB_IDX_W-1:0]  query_idx_i,
  input  logic [`REG_ADDR_W-1:0] src_reg_i,
  input  logic                   lookup_hit_i,
  input  logic                   lookup_done_i,
  input  logic [`XLEN-1:0]       lookup_value_i,
  input  logic [`ROB_IDX_W-1:0]  lookup_slot_i,
  input  logic [`XLEN-1:0]       rf_rdata_i,
  output logic [`ROB_IDX_W-1:0]  lookup_idx_o,
  output logic [`REG_ADDR_W-1:0] lookup_reg_o,
  output logic [`REG_ADDR_W-1:0] rf_raddr_o,
  output logic [`XLEN-1:0]       src_value_o,
  output logic                   src_ready_o,
  output logic [`ROB_IDX_W-1:0]  src_tag_o
);

  // Both sources are probed in parallel
  assign lookup_idx_o = query_idx_i;
  assign lookup_reg_o = src_reg_i;
  assign rf_raddr_o   = src_reg_i;

  always_comb begin
    if (lookup_hit_i) begin
      src_ready_o = lookup_done_i;
      src_tag_o   = lookup_slot_i;
      // Pending producer has no usable result yet
      if (lookup_done_i) begin
        src_value_o = lookup_value_i;
      end else begin
        src_value_o = '0;
      end
    end else begin
      // Nothing in flight writes it, architectural copy is current
      src_ready_o = 1'b1;
      src_tag_o   = '0;
      src_value_o = rf_rdata_i;
    end
  end

endmodule

// ==== verilog/retire_unit.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module retire_unit (
  input  logic                                   clock,
  input  logic                                   reset_n,
  input  rob_pkg::rob_slot_state_t [`ROB_LANES-1:0] head_state_i,
  input  rob_pkg::rob_entry_t [`ROB_LANES-1:0]   head_entry_i,
  input  logic [`ROB_LANES-1:0]                  head_occupied_i,
  output logic                                   consume_o,
  output logic [$clog2(`ROB_LANES)-1:0]          consume_count_o,
  output logic [`ROB_LANES-1:0]                  rf_we_o,
  output logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] rf_waddr_o,
  output logic [`ROB_LANES-1:0][`XLEN-1:0]       rf_wdata_o,
  output logic [`ROB_LANES-1:0]                  retire_valid_o,
  output logic [`ROB_LANES-1:0][`REG_ADDR_W-1:0] retire_reg_o,
  output logic [`ROB_LANES-1:0][`XLEN-1:0]       retire_data_o
);
  import rob_pkg::*;

  logic [`ROB_LANES-1:0] finished;
  logic [`ROB_LANES-1:0] leaving;
  logic [`ROB_LANES-1:0] writes;
  logic [31:0]           retired_total;

  always_comb begin
    for (int l = 0; l < `ROB_LANES; l++) begin
      finished[l] = head_occupied_i[l] &&
                    (head_state_i[l] == SLOT_DONE || head_state_i[l] == SLOT_KILLED);
    end
  end

  // In order only: lane 1 follows lane 0
  assign leaving[0] = finished[0];
  assign leaving[1] = finished[0] & finished[1];

  always_comb begin
    for (int l = 0; l < `ROB_LANES; l++) begin
      writes[l] = leaving[l] && head_state_i[l] == SLOT_DONE &&
                  head_entry_i[l].dest_reg_valid;
      rf_waddr_o[l] = head_entry_i[l].dest_reg;
      rf_wdata_o[l] = head_entry_i[l].result;
    end
  end

  assign consume_o       = leaving[0];
  assign consume_count_o = leaving[1];
  assign rf_we_o         = writes;
  assign retire_valid_o  = writes;
  assign retire_reg_o    = rf_waddr_o;
  assign retire_data_o   = rf_wdata_o;

  // Running total of slots that left the buffer
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      retired_total <= '0;
    end else begin
      retired_total <= retired_total + leaving[0] + leaving[1];
    end
  end

endmodule
